//--- flist.f
verilog/cpu_pkg.sv
verilog/dec_if.sv
verilog/wb_if.sv
verilog/instr_decode.sv
verilog/sequencer.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/cpu_top.sv
tb/clk_gen.sv
tb/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cpu_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module cpu_tb \
	-Mdir obj_dir -o cpu_tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpu_tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$SIM_LOG"; then
	exit 0
fi
exit 1

//--- tb/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_o
);

initial begin
	clk_o = 1'b0;
	forever #(PERIOD / 2) clk_o = ~clk_o;
end

// Power-on reset, released on a falling edge
initial begin
	rst_o = 1'b1;
	repeat (RESET_CYCLES) @(posedge clk_o);
	@(negedge clk_o);
	rst_o = 1'b0;
end

endmodule

//--- tb/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

localparam logic [15:0] START_PC = 16'h0200;
localparam logic [31:0] SEED = 32'hbfb90f6c;
localparam int NUM_RANDOM = 24;
localparam int HALT_LIMIT = 400;
localparam int POR_LIMIT = 20;

typedef enum logic [2:0] {
	T_ADC,
	T_SBC,
	T_AND,
	T_ORA,
	T_EOR
} tb_op_e;

typedef struct packed {
	tb_op_e     op;
	logic       absolute;
	logic [7:0] a;
	logic [7:0] b;
	logic       cin;
	logic [7:0] res;
	logic       c;
	logic       z;
} row_t;

logic        clk;
logic        por_rst;
logic        row_rst;
logic        rst_i;
logic        rdy_i;
logic [15:0] addr_o;
logic [7:0]  data_i;
logic [7:0]  data_o;
logic        we_o;
logic        fetch_o;
logic        halted_o;

logic [7:0]  mem [0:65535];
row_t        rows [$];
logic [23:0] wlog [$];
logic [31:0] rnd_state;
logic [15:0] load_pc;
int          err_count;
int          timeouts;
int          cur_row;

clk_gen u_clk (
	.clk_o(clk),
	.rst_o(por_rst)
);

assign rst_i = por_rst | row_rst;
assign data_i = mem[addr_o];

cpu_top #(.RESET_PC(START_PC)) dut (
	.clk(clk),
	.rst_i(rst_i),
	.rdy_i(rdy_i),
	.addr_o(addr_o),
	.data_i(data_i),
	.data_o(data_o),
	.we_o(we_o),
	.fetch_o(fetch_o),
	.halted_o(halted_o)
);

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Returns {c, z, res}
function automatic logic [9:0] alu_model(input tb_op_e op, input logic [7:0] a, b,
	input logic cin);
	logic [8:0] t;
	logic [7:0] r;
	logic       c;
	c = cin;
	case (op)
	T_ADC: begin
		t = {1'b0, a} + {1'b0, b} + {8'h00, cin};
		r = t[7:0];
		c = t[8];
	end
	// Carry set means no borrow
	T_SBC: begin
		t = {1'b0, a} - {1'b0, b} - {8'h00, ~cin};
		r = t[7:0];
		c = ~t[8];
	end
	T_AND: r = a & b;
	T_ORA: r = a | b;
	default: r = a ^ b;
	endcase
	return {c, r == 8'h00, r};
endfunction

function automatic logic [7:0] imm_opcode(input tb_op_e op);
	case (op)
	T_ADC: return 8'h69;
	T_SBC: return 8'he9;
	T_AND: return 8'h29;
	T_ORA: return 8'h09;
	default: return 8'h49;
	endcase
endfunction

task automatic check_equal(input string name, input logic [15:0] got, input logic [15:0] want);
	if (got !== want) begin
		$display("Mismatch at %0d ns, row %0d: %s = %h, expected %h",
			$time, cur_row, name, got, want);
		err_count++;
	end
endtask

task automatic drive_rdy();
	rnd_state = xorshift32(rnd_state);
	rdy_i = rnd_state[1:0] != 2'b00;
endtask

task automatic fill_memory();
	logic [16:0] i;
	for (i = 17'h00000; i < 17'h10000; i++)
		mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'h5a;
endtask

task automatic add_row(input tb_op_e op, input logic absolute, input logic [7:0] a, b,
	input logic cin, input logic [7:0] res, input logic c, z);
	row_t r;
	r = '{op, absolute, a, b, cin, res, c, z};
	rows.push_back(r);
endtask

task automatic build_table();
	tb_op_e     op;
	logic       absolute;
	logic       cin;
	logic [7:0] a;
	logic [7:0] b;
	logic [9:0] want;
	// op, absolute, a, b, carry in, result, C, Z
	add_row(T_ADC, 1'b0, 8'h10, 8'h20, 1'b0, 8'h30, 1'b0, 1'b0);
	add_row(T_ADC, 1'b0, 8'h50, 8'h50, 1'b0, 8'ha0, 1'b0, 1'b0);
	add_row(T_ADC, 1'b0, 8'hff, 8'h01, 1'b0, 8'h00, 1'b1, 1'b1);
	add_row(T_ADC, 1'b1, 8'h7f, 8'h00, 1'b1, 8'h80, 1'b0, 1'b0);
	add_row(T_ADC, 1'b0, 8'h80, 8'h80, 1'b1, 8'h01, 1'b1, 1'b0);
	add_row(T_ADC, 1'b1, 8'h80, 8'h80, 1'b0, 8'h00, 1'b1, 1'b1);
	add_row(T_SBC, 1'b0, 8'h50, 8'h30, 1'b1, 8'h20, 1'b1, 1'b0);
	add_row(T_SBC, 1'b0, 8'h30, 8'h50, 1'b1, 8'he0, 1'b0, 1'b0);
	add_row(T_SBC, 1'b0, 8'h42, 8'h42, 1'b1, 8'h00, 1'b1, 1'b1);
	add_row(T_SBC, 1'b1, 8'h80, 8'h01, 1'b1, 8'h7f, 1'b1, 1'b0);
	add_row(T_SBC, 1'b0, 8'h10, 8'h10, 1'b0, 8'hff, 1'b0, 1'b0);
	add_row(T_AND, 1'b0, 8'hf0, 8'h0f, 1'b1, 8'h00, 1'b1, 1'b1);
	add_row(T_AND, 1'b1, 8'h3c, 8'h2f, 1'b0, 8'h2c, 1'b0, 1'b0);
	add_row(T_ORA, 1'b0, 8'h00, 8'h00, 1'b0, 8'h00, 1'b0, 1'b1);
	add_row(T_ORA, 1'b1, 8'h81, 8'h18, 1'b1, 8'h99, 1'b1, 1'b0);
	add_row(T_EOR, 1'b0, 8'h5a, 8'h5a, 1'b0, 8'h00, 1'b0, 1'b1);
	add_row(T_EOR, 1'b1, 8'ha5, 8'hff, 1'b1, 8'h5a, 1'b1, 1'b0);
	for (int i = 0; i < NUM_RANDOM; i++) begin
		rnd_state = xorshift32(rnd_state);
		op = tb_op_e'(3'(rnd_state[15:0] % 16'd5));
		absolute = rnd_state[16];
		cin = rnd_state[17];
		rnd_state = xorshift32(rnd_state);
		a = rnd_state[7:0];
		b = rnd_state[15:8];
		want = alu_model(op, a, b, cin);
		add_row(op, absolute, a, b, cin, want[7:0], want[9], want[8]);
	end
endtask

task automatic put_instr(input logic [7:0] opc, input logic [15:0] operand, input int nbytes);
	mem[load_pc] = opc;
	load_pc = load_pc + 16'd1;
	if (nbytes > 1) begin
		mem[load_pc] = operand[7:0];
		load_pc = load_pc + 16'd1;
	end
	if (nbytes > 2) begin
		mem[load_pc] = operand[15:8];
		load_pc = load_pc + 16'd1;
	end
endtask

task automatic load_program(input row_t r);
	load_pc = START_PC;
	put_instr(8'ha2, 16'h0000, 2);
	put_instr(8'ha0, 16'h0000, 2);
	put_instr(8'ha9, {8'h00, r.a}, 2);
	put_instr(r.cin ? 8'h38 : 8'h18, 16'h0000, 1);
	if (r.absolute) begin
		mem[16'h0400] = r.b;
		put_instr(imm_opcode(r.op) + 8'h04, 16'h0400, 3);
	end else begin
		put_instr(imm_opcode(r.op), {8'h00, r.b}, 2);
	end
	put_instr(8'h8d, 16'h0300, 3);
	// BNE over INY, BCC over INX
	put_instr(8'hd0, 16'h0001, 2);
	put_instr(8'hc8, 16'h0000, 1);
	put_instr(8'h90, 16'h0001, 2);
	put_instr(8'he8, 16'h0000, 1);
	put_instr(8'h8e, 16'h0301, 3);
	put_instr(8'h8c, 16'h0302, 3);
	put_instr(8'h00, 16'h0000, 1);
endtask

task automatic wait_por();
	int n;
	n = 0;
	while (por_rst !== 1'b0 && n < POR_LIMIT) begin
		@(negedge clk);
		#1;
		n++;
	end
	if (por_rst !== 1'b0) begin
		$display("Power-on reset was never released");
		timeouts++;
	end
endtask

task automatic run_row(input int idx, input row_t r);
	int          cycles;
	logic        stalled;
	logic [24:0] held;
	cur_row = idx;
	@(negedge clk);
	row_rst = 1'b1;
	rdy_i = 1'b1;
	repeat (8) @(negedge clk);
	load_program(r);
	wlog.delete();
	row_rst = 1'b0;
	drive_rdy();
	#1;
	check_equal("fetch_o", 16'(fetch_o), 16'h0001);
	check_equal("addr_o", addr_o, START_PC);
	check_equal("we_o", 16'(we_o), 16'h0000);
	check_equal("halted_o", 16'(halted_o), 16'h0000);
	cycles = 0;
	stalled = 1'b0;
	while (halted_o !== 1'b1 && cycles < HALT_LIMIT) begin
		// Bus is stable here for the coming rising edge
		if (rdy_i && we_o)
			wlog.push_back({addr_o, data_o});
		stalled = !rdy_i;
		held = {we_o, addr_o, data_o};
		@(negedge clk);
		drive_rdy();
		#1;
		if (stalled) begin
			check_equal("we_o after stall", 16'(we_o), 16'(held[24]));
			check_equal("addr_o after stall", addr_o, held[23:8]);
			check_equal("data_o after stall", 16'(data_o), 16'(held[7:0]));
		end
		cycles++;
	end
	if (halted_o !== 1'b1) begin
		$display("Row %0d: CPU did not halt within %0d cycles", idx, HALT_LIMIT);
		timeouts++;
	end else begin
		check_equal("write count", 16'(wlog.size()), 16'd3);
		if (wlog.size() == 3) begin
			check_equal("STA addr_o", wlog[0][23:8], 16'h0300);
			check_equal("STA data_o", 16'(wlog[0][7:0]), 16'(r.res));
			check_equal("STX addr_o", wlog[1][23:8], 16'h0301);
			check_equal("STX data_o", 16'(wlog[1][7:0]), 16'(r.c));
			check_equal("STY addr_o", wlog[2][23:8], 16'h0302);
			check_equal("STY data_o", 16'(wlog[2][7:0]), 16'(r.z));
		end
	end
endtask

initial begin
	int rows_run;
	row_rst = 1'b1;
	rdy_i = 1'b1;
	err_count = 0;
	timeouts = 0;
	cur_row = 0;
	rows_run = 0;
	load_pc = START_PC;
	rnd_state = SEED;
	fill_memory();
	build_table();
	wait_por();
	for (int i = 0; i < rows.size() && timeouts == 0; i++) begin
		run_row(i, rows[i]);
		rows_run++;
	end
	$display("Rows run: %0d, mismatches: %0d, timeouts: %0d", rows_run, err_count, timeouts);
	if (err_count == 0 && timeouts == 0)
		$display("sim passed");
	else
		$display("sim failed");
	$finish;
end

endmodule

//--- verilog/alu.sv
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
	input alu_func_e   func_i,
	input logic [7:0]  a_i,
	input logic [7:0]  b_i,
	input logic        cin_i,
	output logic [7:0] res_o,
	output logic [3:0] flags_o
);

logic [7:0] b_op;
logic       c_op;
logic [8:0] sum;
logic       ovf;

always_comb begin
	b_op = b_i;
	c_op = cin_i;
	case (func_i)
	ALU_SUB: b_op = ~b_i;
	ALU_INC: c_op = 1'b0;
	// a + ~b + 1 with b holding one
	ALU_DEC: begin
		b_op = ~b_i;
		c_op = 1'b1;
	end
	default: ;
	endcase
end

assign sum = {1'b0, a_i} + {1'b0, b_op} + {8'h00, c_op};
assign ovf = (a_i[7] == b_op[7]) && (sum[7] != a_i[7]);

always_comb begin
	case (func_i)
	ALU_AND: res_o = a_i & b_i;
	ALU_OR:  res_o = a_i | b_i;
	ALU_EOR: res_o = a_i ^ b_i;
	ALU_PASS: res_o = b_i;
	default: res_o = sum[7:0];
	endcase
end

// N, V, Z, C
assign flags_o = {res_o[7], ovf, res_o == 8'h00, sum[8]};

endmodule

//--- verilog/cpu_pkg.sv
package cpu_pkg;

	// Opcode byte as the aaa/bbb/cc field split
	typedef struct packed {
		logic [2:0] aaa;
		logic [2:0] bbb;
		logic [1:0] cc;
	} opcode_fields_t;

	typedef union packed {
		logic [7:0]     raw;
		opcode_fields_t f;
	} opcode_u;

	typedef enum logic [3:0] {
		OP_LOAD,
		OP_STORE,
		OP_ALU,
		OP_TRANSFER,
		OP_INCDEC,
		OP_FLAG,
		OP_JUMP,
		OP_BRANCH,
		OP_HALT,
		OP_ILLEGAL
	} op_e;

	typedef enum logic [1:0] {
		MODE_IMPLIED,
		MODE_IMMEDIATE,
		MODE_ABSOLUTE
	} mode_e;

	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_INC,
		ALU_DEC
	} alu_func_e;

	typedef enum logic [1:0] {
		REG_A,
		REG_X,
		REG_Y,
		REG_NONE
	} reg_sel_e;

	// Bit positions in P
	localparam int unsigned STATUS_C = 0;
	localparam int unsigned STATUS_Z = 1;
	localparam int unsigned STATUS_V = 6;
	localparam int unsigned STATUS_N = 7;

	localparam logic [15:0] RESET_PC_DEFAULT = 16'h0200;

endpackage

//--- verilog/cpu_top.sv
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; #(
	parameter logic [15:0] RESET_PC = RESET_PC_DEFAULT
) (
	input logic         clk,
	input logic         rst_i,
	input logic         rdy_i,
	output logic [15:0] addr_o,
	input logic [7:0]   data_i,
	output logic [7:0]  data_o,
	output logic        we_o,
	output logic        fetch_o,
	output logic        halted_o
);

dec_if dec_bus ();
wb_if  wb_bus ();

opcode_u    opcode;
logic [7:0] alu_a, alu_b, alu_res;
logic [3:0] alu_flags;
logic       rf_en;

instr_decode u_decode (
	.opcode_i(opcode),
	.dec(dec_bus.dec)
);

sequencer #(.RESET_PC(RESET_PC)) u_seq (
	.clk(clk),
	.rst_i(rst_i),
	.rdy_i(rdy_i),
	.data_i(data_i),
	.addr_o(addr_o),
	.data_o(data_o),
	.we_o(we_o),
	.fetch_o(fetch_o),
	.halted_o(halted_o),
	.opcode_o(opcode),
	.dec(dec_bus.seq),
	.wb(wb_bus.exec),
	.alu_a_o(alu_a),
	.alu_b_o(alu_b),
	.alu_res_i(alu_res),
	.alu_flags_i(alu_flags),
	.rf_en_o(rf_en)
);

// Carry in always comes from P
alu u_alu (
	.func_i(dec_bus.alu_func),
	.a_i(alu_a),
	.b_i(alu_b),
	.cin_i(wb_bus.p_val[STATUS_C]),
	.res_o(alu_res),
	.flags_o(alu_flags)
);

reg_file u_regs (
	.clk(clk),
	.rst_i(rst_i),
	.en_i(rf_en),
	.wb(wb_bus.rf)
);

endmodule

//--- verilog/dec_if.sv
`timescale 1ns/10ps

interface dec_if import cpu_pkg::*; ();

	op_e        op;
	mode_e      mode;
	alu_func_e  alu_func;
	reg_sel_e   src_sel;
	reg_sel_e   dst_sel;
	logic [7:0] flag_mask;
	logic [7:0] flag_set;
	logic [7:0] flag_clr;
	logic [2:0] branch_bit;
	logic       branch_val;

	modport dec (output op, mode, alu_func, src_sel, dst_sel,
		flag_mask, flag_set, flag_clr, branch_bit, branch_val);

	modport seq (input op, mode, alu_func, src_sel, dst_sel,
		flag_mask, flag_set, flag_clr, branch_bit, branch_val);

endinterface

//--- verilog/instr_decode.sv
`timescale 1ns/10ps

module instr_decode import cpu_pkg::*; (
	input opcode_u opcode_i,
	dec_if.dec dec
);

localparam logic [7:0] MASK_NZ = (8'h01 << STATUS_N) | (8'h01 << STATUS_Z);
localparam logic [7:0] MASK_NVZC = MASK_NZ | (8'h01 << STATUS_V) | (8'h01 << STATUS_C);

reg_sel_e ls_reg;
logic     ls_ok;

always_comb begin
	dec.op = OP_ILLEGAL;
	dec.mode = MODE_IMPLIED;
	dec.alu_func = ALU_PASS;
	dec.src_sel = REG_NONE;
	dec.dst_sel = REG_NONE;
	dec.flag_mask = 8'h00;
	dec.flag_set = 8'h00;
	dec.flag_clr = 8'h00;
	dec.branch_bit = 3'(STATUS_Z);
	dec.branch_val = 1'b0;
	ls_reg = REG_NONE;
	ls_ok = 1'b0;

	case (opcode_i.raw)
	8'h00: dec.op = OP_HALT;
	8'h18: begin
		dec.op = OP_FLAG;
		dec.flag_clr = 8'h01 << STATUS_C;
	end
	8'h38: begin
		dec.op = OP_FLAG;
		dec.flag_set = 8'h01 << STATUS_C;
	end
	8'h4c: begin
		dec.op = OP_JUMP;
		dec.mode = MODE_ABSOLUTE;
	end
	8'haa, 8'ha8, 8'h8a, 8'h98: begin
		dec.op = OP_TRANSFER;
		dec.src_sel = opcode_i.raw[4] ? REG_Y : (opcode_i.raw[5] ? REG_A : REG_X);
		dec.dst_sel = (opcode_i.raw == 8'haa) ? REG_X :
			(opcode_i.raw == 8'ha8) ? REG_Y : REG_A;
	end
	8'he8, 8'hc8, 8'hca, 8'h88: begin
		dec.op = OP_INCDEC;
		dec.alu_func = (opcode_i.raw == 8'he8 || opcode_i.raw == 8'hc8) ? ALU_INC : ALU_DEC;
		dec.src_sel = (opcode_i.raw[1] || opcode_i.raw[5]) ? REG_X : REG_Y;
		dec.dst_sel = dec.src_sel;
	end
	// Branches test bit 6 of the opcode for C or Z, bit 5 for the wanted value
	8'hf0, 8'hd0, 8'h90, 8'hb0: begin
		dec.op = OP_BRANCH;
		dec.mode = MODE_IMMEDIATE;
		dec.branch_bit = opcode_i.raw[6] ? 3'(STATUS_Z) : 3'(STATUS_C);
		dec.branch_val = opcode_i.raw[5];
	end
	default: begin
		ls_reg = (opcode_i.f.cc == 2'b01) ? REG_A :
			(opcode_i.f.cc == 2'b10) ? REG_X : REG_Y;
		if (opcode_i.f.bbb == 3'b011)
			dec.mode = MODE_ABSOLUTE;
		else if (opcode_i.f.bbb == ((opcode_i.f.cc == 2'b01) ? 3'b010 : 3'b000))
			dec.mode = MODE_IMMEDIATE;
		ls_ok = (dec.mode != MODE_IMPLIED) && (opcode_i.f.cc != 2'b11);

		if (ls_ok && opcode_i.f.aaa == 3'b101) begin
			dec.op = OP_LOAD;
			dec.dst_sel = ls_reg;
		end else if (ls_ok && opcode_i.f.aaa == 3'b100 && dec.mode == MODE_ABSOLUTE) begin
			dec.op = OP_STORE;
			dec.src_sel = ls_reg;
		end else if (ls_ok && opcode_i.f.cc == 2'b01 && opcode_i.f.aaa != 3'b110
				&& opcode_i.f.aaa != 3'b100) begin
			dec.op = OP_ALU;
			dec.src_sel = REG_A;
			dec.dst_sel = REG_A;
			case (opcode_i.f.aaa)
			3'b000: dec.alu_func = ALU_OR;
			3'b001: dec.alu_func = ALU_AND;
			3'b010: dec.alu_func = ALU_EOR;
			3'b011: dec.alu_func = ALU_ADD;
			default: dec.alu_func = ALU_SUB;
			endcase
		end else begin
			dec.mode = MODE_IMPLIED;
		end
	end
	endcase

	// Only ADC and SBC touch C and V
	if (dec.op == OP_ALU && (dec.alu_func == ALU_ADD || dec.alu_func == ALU_SUB))
		dec.flag_mask = MASK_NVZC;
	else if (dec.op inside {OP_LOAD, OP_ALU, OP_TRANSFER, OP_INCDEC})
		dec.flag_mask = MASK_NZ;
end

always_comb begin
	if (opcode_i.raw == 8'h18 || opcode_i.raw == 8'h38)
		assert ((dec.flag_set != 8'h00) != (dec.flag_clr != 8'h00))
		else $error("flag opcode %h drives both or neither of set and clear", opcode_i.raw);
end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file import cpu_pkg::*; (
	input logic clk,
	input logic rst_i,
	input logic en_i,
	wb_if.rf    wb
);

logic [7:0] a_q, x_q, y_q, p_q;
logic [7:0] p_next;

// Keep unmasked bits, then force set and clear
assign p_next = ((~wb.flag_mask & p_q) | (wb.flag_mask & wb.flags_in) | wb.flag_set)
	& ~wb.flag_clr;

always_ff @(posedge clk) begin
	if (en_i && wb.reg_we) begin
		case (wb.dst_sel)
		REG_A: a_q <= wb.alu_res;
		REG_X: x_q <= wb.alu_res;
		REG_Y: y_q <= wb.alu_res;
		default: ;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (rst_i)
		p_q <= 8'h00;
	else if (en_i && wb.flags_we)
		p_q <= p_next;
end

assign wb.a_val = a_q;
assign wb.x_val = x_q;
assign wb.y_val = y_q;
assign wb.p_val = p_q;

a_we_has_dest: assert property (@(posedge clk) disable iff (rst_i)
	wb.reg_we |-> wb.dst_sel != REG_NONE)
	else $error("register write with no destination");

endmodule

//--- verilog/sequencer.sv
`timescale 1ns/10ps

module sequencer import cpu_pkg::*; #(
	parameter logic [15:0] RESET_PC = RESET_PC_DEFAULT
) (
	input logic         clk,
	input logic         rst_i,
	input logic         rdy_i,
	input logic [7:0]   data_i,
	output logic [15:0] addr_o,
	output logic [7:0]  data_o,
	output logic        we_o,
	output logic        fetch_o,
	output logic        halted_o,
	output opcode_u     opcode_o,
	dec_if.seq          dec,
	wb_if.exec          wb,
	output logic [7:0]  alu_a_o,
	output logic [7:0]  alu_b_o,
	input logic [7:0]   alu_res_i,
	input logic [3:0]   alu_flags_i,
	output logic        rf_en_o
);

typedef enum logic [2:0] {
	S_FETCH,
	S_OPER,
	S_ADH,
	S_DATA,
	S_BRANCH,
	S_HALT
} state_e;

state_e      state;
logic [15:0] pc;
opcode_u     ir;
logic [7:0]  adl, adh;
logic [7:0]  src_val;
logic [15:0] branch_target;
logic        taken;
logic        last_cycle;
logic        writes_reg;

assign taken = wb.p_val[dec.branch_bit] == dec.branch_val;
assign branch_target = pc + 16'd1 + {{8{data_i[7]}}, data_i};

always_ff @(posedge clk) begin
	if (rst_i) begin
		state <= S_FETCH;
		pc <= RESET_PC;
	end else if (rdy_i) begin
		case (state)
		S_FETCH: begin
			pc <= pc + 16'd1;
			state <= S_OPER;
		end
		S_OPER: begin
			if (dec.mode != MODE_IMPLIED)
				pc <= pc + 16'd1;
			case (dec.op)
			OP_HALT, OP_ILLEGAL: state <= S_HALT;
			OP_BRANCH: begin
				if (taken) begin
					pc <= branch_target;
					state <= S_BRANCH;
				end else begin
					state <= S_FETCH;
				end
			end
			default: state <= (dec.mode == MODE_ABSOLUTE) ? S_ADH : S_FETCH;
			endcase
		end
		S_ADH: begin
			if (dec.op == OP_JUMP) begin
				pc <= {data_i, adl};
				state <= S_FETCH;
			end else begin
				pc <= pc + 16'd1;
				state <= S_DATA;
			end
		end
		S_DATA, S_BRANCH: state <= S_FETCH;
		default: state <= S_HALT;
		endcase
	end
end

// Opcode and address bytes
always_ff @(posedge clk) begin
	if (rdy_i) begin
		if (state == S_FETCH)
			ir.raw <= data_i;
		if (state == S_OPER)
			adl <= data_i;
		if (state == S_ADH)
			adh <= data_i;
	end
end

assign opcode_o = ir;
assign addr_o = (state == S_DATA) ? {adh, adl} : pc;
assign we_o = (state == S_DATA) && (dec.op == OP_STORE);
assign data_o = we_o ? alu_res_i : 8'h00;
assign fetch_o = state == S_FETCH;
assign halted_o = state == S_HALT;
assign rf_en_o = rdy_i;

always_comb begin
	case (dec.src_sel)
	REG_A: src_val = wb.a_val;
	REG_X: src_val = wb.x_val;
	REG_Y: src_val = wb.y_val;
	default: src_val = 8'h00;
	endcase
	alu_a_o = src_val;
	if (dec.op == OP_INCDEC)
		alu_b_o = 8'h01;
	else if (dec.op == OP_STORE || dec.op == OP_TRANSFER)
		alu_b_o = src_val;
	else
		alu_b_o = data_i;
end

// Results land at the end of an instruction's final cycle
assign last_cycle = (state == S_OPER && dec.mode != MODE_ABSOLUTE) || state == S_DATA;
assign writes_reg = dec.op inside {OP_LOAD, OP_ALU, OP_TRANSFER, OP_INCDEC};

assign wb.alu_res = alu_res_i;
assign wb.reg_we = last_cycle && writes_reg;
assign wb.flags_we = last_cycle && (writes_reg || dec.op == OP_FLAG);
assign wb.dst_sel = dec.dst_sel;
assign wb.flag_mask = dec.flag_mask;
assign wb.flag_set = dec.flag_set;
assign wb.flag_clr = dec.flag_clr;

always_comb begin
	wb.flags_in = 8'h00;
	wb.flags_in[STATUS_N] = alu_flags_i[3];
	wb.flags_in[STATUS_V] = alu_flags_i[2];
	wb.flags_in[STATUS_Z] = alu_flags_i[1];
	wb.flags_in[STATUS_C] = alu_flags_i[0];
end

a_no_write_on_fetch: assert property (@(posedge clk) disable iff (rst_i)
	!(we_o && fetch_o))
	else $error("write during opcode fetch");

// A stalled cycle must present the same bus request again
a_stall_holds_bus: assert property (@(posedge clk) disable iff (rst_i)
	!rdy_i |=> $stable(addr_o) && $stable(we_o))
	else $error("bus request changed during stall");

endmodule

//--- verilog/wb_if.sv
`timescale 1ns/10ps

interface wb_if import cpu_pkg::*; ();

	logic [7:0] alu_res;
	logic [7:0] flags_in;
	logic       reg_we;
	reg_sel_e   dst_sel;
	logic       flags_we;
	logic [7:0] flag_mask;
	logic [7:0] flag_set;
	logic [7:0] flag_clr;
	logic [7:0] a_val, x_val, y_val, p_val;

	modport exec (output alu_res, flags_in, reg_we, dst_sel, flags_we,
		flag_mask, flag_set, flag_clr, input a_val, x_val, y_val, p_val);

	modport rf (input alu_res, flags_in, reg_we, dst_sel, flags_we,
		flag_mask, flag_set, flag_clr, output a_val, x_val, y_val, p_val);

endinterface
